// ==== hdl/m92_rom_pkg.sv ====
`default_nettype none

package m92_rom_pkg;

	// Region codes found in the first header byte
	typedef enum logic [7:0] {
		SDR   = 8'd0,
		BRAM0 = 8'd1,
		BRAM1 = 8'd2,
		BRAM2 = 8'd3,
		BRAM3 = 8'd4,
		END   = 8'd255
	} region_t;

	// Code byte plus 24-bit big-endian length
	localparam int HDR_BYTES = 4;

	// Leading image byte, handed to the core as is
	localparam int BOARD_CFG_W = 8;

endpackage

`default_nettype wire

// ==== hdl/m92_mem_pkg.sv ====
`default_nettype none

package m92_mem_pkg;

	// SDRAM port word, written little-endian
	localparam int SDR_WORD_W = 16;

	// On-chip ROM banks, one chip-select each
	localparam int BRAM_BANKS = 4;

	// Word packer states
	typedef enum logic [1:0] {
		IDLE,
		HAVE_LOW,
		WAIT_ACK
	} pack_state_t;

endpackage

`default_nettype wire

// ==== hdl/rom_header_parser.sv ====
`default_nettype none
`timescale 1ns/1ns

module rom_header_parser
	import m92_rom_pkg::*, m92_mem_pkg::*;
#(
	parameter int BRAM_ADDR_W = 20
) (
	input  wire                     CLK_40M,
	input  wire                     reset,
	input  wire                     download,
	input  wire                     byte_take,
	input  wire [7:0]               in_data,
	input  wire                     sdr_busy,
	output logic                    sdr_byte_next,
	output logic                    sdr_byte_valid,
	output logic [7:0]              sdr_byte,
	output logic                    sdr_flush,
	output logic [BRAM_ADDR_W-1:0]  bram_addr,
	output logic [7:0]              bram_data,
	output logic [BRAM_BANKS-1:0]   bram_cs,
	output logic                    bram_wr,
	output logic [BOARD_CFG_W-1:0]  board_cfg,
	output logic                    cfg_valid,
	output logic                    end_seen
);

	typedef enum logic [1:0] {CFG, HDR, DATA, DONE} parse_state_t;

	localparam int HDR_CNT_W = $clog2(HDR_BYTES);

	parse_state_t           state;
	region_t                region;
	logic [HDR_CNT_W-1:0]   hdr_cnt;
	logic [23:0]            remain;
	logic                   sdr_hi;
	logic [BRAM_ADDR_W-1:0] bram_next;
	logic                   dl_d;

	// Unknown codes terminate the image
	function automatic region_t decode_region(input logic [7:0] code);
		case (code)
			8'd0:    return SDR;
			8'd1:    return BRAM0;
			8'd2:    return BRAM1;
			8'd3:    return BRAM2;
			8'd4:    return BRAM3;
			default: return END;
		endcase
	endfunction

	function automatic logic [BRAM_BANKS-1:0] bank_sel(input logic [7:0] code);
		logic [BRAM_BANKS-1:0] sel;
		for (int i = 0; i < BRAM_BANKS; i++)
			sel[i] = (code == 8'(i + 1));
		return sel;
	endfunction

	// Next byte would complete an SDRAM word, or is the odd last byte
	assign sdr_byte_next = (state == DATA) && (region == SDR) && (sdr_hi || remain == 24'd1);

	// Image finished once the last word has left the packer
	assign end_seen = (state == DONE) && !sdr_busy;

	always_ff @(posedge CLK_40M) begin
		if (reset) begin
			state          <= CFG;
			hdr_cnt        <= '0;
			cfg_valid      <= 1'b0;
			sdr_byte_valid <= 1'b0;
			sdr_flush      <= 1'b0;
			bram_wr        <= 1'b0;
			bram_cs        <= '0;
			dl_d           <= 1'b0;
		end else begin
			dl_d           <= download;
			sdr_byte_valid <= 1'b0;
			sdr_flush      <= 1'b0;
			bram_wr        <= 1'b0;
			if (download && !dl_d)
				cfg_valid <= 1'b0;
			if (!download) begin
				state   <= CFG;
				hdr_cnt <= '0;
			end else if (byte_take) begin
				case (state)
					CFG: begin
						board_cfg <= in_data;
						cfg_valid <= 1'b1;
						state     <= HDR;
					end
					HDR: begin
						hdr_cnt <= hdr_cnt + 1'b1;
						if (hdr_cnt == '0) begin
							region  <= decode_region(in_data);
							bram_cs <= bank_sel(in_data);
						end else if (hdr_cnt == HDR_CNT_W'(HDR_BYTES - 1)) begin
							hdr_cnt   <= '0;
							remain    <= {remain[15:0], in_data};
							sdr_hi    <= 1'b0;
							bram_next <= '0;
							if (region == END)
								state <= DONE;
							else if ({remain[15:0], in_data} != 24'd0)
								state <= DATA;
						end else begin
							// Length arrives MSB first
							remain <= {remain[15:0], in_data};
						end
					end
					DATA: begin
						remain <= remain - 24'd1;
						if (remain == 24'd1)
							state <= HDR;
						if (region == SDR) begin
							sdr_byte_valid <= 1'b1;
							sdr_byte       <= in_data;
							sdr_flush      <= (remain == 24'd1) && !sdr_hi;
							sdr_hi         <= !sdr_hi;
						end else begin
							bram_wr   <= 1'b1;
							bram_data <= in_data;
							bram_addr <= bram_next;
							bram_next <= bram_next + 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sdram_word_packer.sv ====
`default_nettype none
`timescale 1ns/1ns

module sdram_word_packer
	import m92_mem_pkg::*;
#(
	parameter int SDR_ADDR_W = 25
) (
	input  wire                       CLK_40M,
	input  wire                       reset,
	input  wire                       download,
	input  wire                       byte_valid,
	input  wire [7:0]                 byte_data,
	input  wire                       flush,
	input  wire                       sdr_ack,
	output logic                      busy,
	output logic [SDR_ADDR_W-1:0]     sdr_addr,
	output logic [SDR_WORD_W-1:0]     sdr_data,
	output logic [SDR_WORD_W/8-1:0]   sdr_be,
	output logic                      sdr_req
);

	pack_state_t state;
	logic [7:0]  low_byte;
	logic        low_pend;
	logic        dl_d;

	assign busy = (state == WAIT_ACK);

	always_ff @(posedge CLK_40M) begin
		if (reset) begin
			state    <= IDLE;
			sdr_req  <= sdr_ack;
			sdr_addr <= '0;
			low_pend <= 1'b0;
			dl_d     <= 1'b0;
		end else begin
			dl_d <= download;
			case (state)
				IDLE: begin
					if (byte_valid && flush) begin
						// Odd tail, high byte left empty
						sdr_data <= {{(SDR_WORD_W - 8){1'b0}}, byte_data};
						sdr_be   <= (SDR_WORD_W/8)'(1);
						sdr_req  <= !sdr_req;
						state    <= WAIT_ACK;
					end else if (byte_valid) begin
						low_byte <= byte_data;
						state    <= HAVE_LOW;
					end
				end
				HAVE_LOW: begin
					if (byte_valid) begin
						sdr_data <= {byte_data, low_byte};
						sdr_be   <= '1;
						sdr_req  <= !sdr_req;
						state    <= WAIT_ACK;
					end
				end
				WAIT_ACK: begin
					// Only a low byte can arrive here
					if (byte_valid) begin
						low_byte <= byte_data;
						low_pend <= 1'b1;
					end
					if (sdr_ack == sdr_req) begin
						sdr_addr <= sdr_addr + SDR_ADDR_W'(2);
						low_pend <= 1'b0;
						state    <= (low_pend || byte_valid) ? HAVE_LOW : IDLE;
					end
				end
				default: state <= IDLE;
			endcase
			// New image restarts at address 0
			if (download && !dl_d)
				sdr_addr <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/rom_loader.sv ====
`default_nettype none
`timescale 1ns/1ns

module rom_loader
	import m92_rom_pkg::*, m92_mem_pkg::*;
#(
	parameter int SDR_ADDR_W  = 25,
	parameter int BRAM_ADDR_W = 20
) (
	input  wire                      CLK_40M,
	input  wire                      reset,
	input  wire                      download,
	input  wire                      in_valid,
	output logic                     in_ready,
	input  wire [7:0]                in_data,
	output logic [SDR_ADDR_W-1:0]    sdr_addr,
	output logic [SDR_WORD_W-1:0]    sdr_data,
	output logic [SDR_WORD_W/8-1:0]  sdr_be,
	output logic                     sdr_req,
	input  wire                      sdr_ack,
	output logic [BRAM_ADDR_W-1:0]   bram_addr,
	output logic [7:0]               bram_data,
	output logic [BRAM_BANKS-1:0]    bram_cs,
	output logic                     bram_wr,
	output logic [BOARD_CFG_W-1:0]   board_cfg,
	output logic                     cfg_valid,
	output logic                     load_done
);

	logic       byte_take;
	logic       sdr_byte_next;
	logic       sdr_byte_valid;
	logic [7:0] sdr_byte;
	logic       sdr_flush;
	logic       sdr_busy;
	logic       end_seen;

	// Stall only a word-completing SDRAM byte while a write is in flight
	assign in_ready  = !(sdr_byte_next && sdr_busy);
	assign byte_take = in_valid && in_ready;

	always_ff @(posedge CLK_40M) begin
		if (reset)
			load_done <= 1'b0;
		else if (end_seen)
			load_done <= 1'b1;
		else if (download && !cfg_valid)
			load_done <= 1'b0;  // new image under way
	end

	rom_header_parser #(
		.BRAM_ADDR_W(BRAM_ADDR_W)
	) rom_header_parser_inst (
		.CLK_40M        (CLK_40M),
		.reset          (reset),
		.download       (download),
		.byte_take      (byte_take),
		.in_data        (in_data),
		.sdr_busy       (sdr_busy),
		.sdr_byte_next  (sdr_byte_next),
		.sdr_byte_valid (sdr_byte_valid),
		.sdr_byte       (sdr_byte),
		.sdr_flush      (sdr_flush),
		.bram_addr      (bram_addr),
		.bram_data      (bram_data),
		.bram_cs        (bram_cs),
		.bram_wr        (bram_wr),
		.board_cfg      (board_cfg),
		.cfg_valid      (cfg_valid),
		.end_seen       (end_seen)
	);

	sdram_word_packer #(
		.SDR_ADDR_W(SDR_ADDR_W)
	) sdram_word_packer_inst (
		.CLK_40M    (CLK_40M),
		.reset      (reset),
		.download   (download),
		.byte_valid (sdr_byte_valid),
		.byte_data  (sdr_byte),
		.flush      (sdr_flush),
		.sdr_ack    (sdr_ack),
		.busy       (sdr_busy),
		.sdr_addr   (sdr_addr),
		.sdr_data   (sdr_data),
		.sdr_be     (sdr_be),
		.sdr_req    (sdr_req)
	);

endmodule

`default_nettype wire

// ==== hdl/core_reset_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ns

module core_reset_ctrl (
	input  wire  CLK_40M,
	input  wire  reset,
	input  wire  download,
	input  wire  reset_req,
	output logic core_reset,
	output logic rom_loaded
);

	logic dl_d;

	always_ff @(posedge CLK_40M) begin
		if (reset) begin
			dl_d       <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			dl_d <= download;
			if (download && !dl_d)
				rom_loaded <= 1'b0;
			else if (dl_d && !download)
				rom_loaded <= 1'b1;
			// Core held until an image is in place
			core_reset <= reset_req || !rom_loaded;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/m92_boot_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module m92_boot_top
	import m92_rom_pkg::*, m92_mem_pkg::*;
#(
	parameter int SDR_ADDR_W  = 25,
	parameter int BRAM_ADDR_W = 20
) (
	input  wire                      CLK_40M,
	input  wire                      reset,
	input  wire                      download,
	input  wire                      in_valid,
	output logic                     in_ready,
	input  wire [7:0]                in_data,
	output logic [SDR_ADDR_W-1:0]    sdr_addr,
	output logic [SDR_WORD_W-1:0]    sdr_data,
	output logic [SDR_WORD_W/8-1:0]  sdr_be,
	output logic                     sdr_req,
	input  wire                      sdr_ack,
	output logic [BRAM_ADDR_W-1:0]   bram_addr,
	output logic [7:0]               bram_data,
	output logic [BRAM_BANKS-1:0]    bram_cs,
	output logic                     bram_wr,
	output logic [BOARD_CFG_W-1:0]   board_cfg,
	output logic                     cfg_valid,
	input  wire                      reset_req,
	output logic                     core_reset,
	output logic                     load_done
);

	rom_loader #(
		.SDR_ADDR_W  (SDR_ADDR_W),
		.BRAM_ADDR_W (BRAM_ADDR_W)
	) rom_loader_inst (
		.CLK_40M   (CLK_40M),
		.reset     (reset),
		.download  (download),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (in_data),
		.sdr_addr  (sdr_addr),
		.sdr_data  (sdr_data),
		.sdr_be    (sdr_be),
		.sdr_req   (sdr_req),
		.sdr_ack   (sdr_ack),
		.bram_addr (bram_addr),
		.bram_data (bram_data),
		.bram_cs   (bram_cs),
		.bram_wr   (bram_wr),
		.board_cfg (board_cfg),
		.cfg_valid (cfg_valid),
		.load_done (load_done)
	);

	core_reset_ctrl core_reset_ctrl_inst (
		.CLK_40M    (CLK_40M),
		.reset      (reset),
		.download   (download),
		.reset_req  (reset_req),
		.core_reset (core_reset),
		.rom_loaded ()
	);

endmodule

`default_nettype wire

// ==== verif/m92_boot_checker.sv ====
`default_nettype none
`timescale 1ns/1ns

module m92_boot_checker
	import m92_mem_pkg::*;
#(
	parameter int SDR_ADDR_W = 25
) (
	input wire                   CLK_40M,
	input wire                   reset,
	input wire                   sdr_req,
	input wire                   sdr_ack,
	input wire [SDR_ADDR_W-1:0]  sdr_addr,
	input wire [SDR_WORD_W-1:0]  sdr_data,
	input wire [BRAM_BANKS-1:0]  bram_cs,
	input wire                   bram_wr
);

	// One write in flight at a time
	req_quiet_while_pending: assert property (
		@(posedge CLK_40M) disable iff (reset)
		(sdr_req != sdr_ack) |=> $stable(sdr_req)
	) else $error("sdr_req toggled while a request was outstanding");

	addr_data_held: assert property (
		@(posedge CLK_40M) disable iff (reset)
		(sdr_req != sdr_ack) |=> ($stable(sdr_addr) && $stable(sdr_data))
	) else $error("sdr_addr or sdr_data changed during an outstanding request");

	bram_cs_onehot: assert property (
		@(posedge CLK_40M) disable iff (reset)
		bram_wr |-> $onehot(bram_cs)
	) else $error("bram_cs not one-hot during a BRAM write");

endmodule

bind rom_loader m92_boot_checker #(
	.SDR_ADDR_W (SDR_ADDR_W)
) m92_boot_checker_inst (
	.CLK_40M  (CLK_40M),
	.reset    (reset),
	.sdr_req  (sdr_req),
	.sdr_ack  (sdr_ack),
	.sdr_addr (sdr_addr),
	.sdr_data (sdr_data),
	.bram_cs  (bram_cs),
	.bram_wr  (bram_wr)
);

`default_nettype wire

// ==== verif/m92_boot_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

module m92_boot_tb
	import m92_rom_pkg::*, m92_mem_pkg::*;
();

	localparam int SDR_ADDR_W  = 25;
	localparam int BRAM_ADDR_W = 20;
	localparam int CLK_PERIOD  = 100;
	// Config byte, nine region headers, 47 data bytes
	localparam int IMAGE_BYTES     = 1 + 9 * HDR_BYTES + 47;
	localparam int WATCHDOG_CYCLES = IMAGE_BYTES * 10 + 1000;

	logic                      CLK_40M;
	logic                      reset;
	logic                      download;
	logic                      in_valid;
	logic                      in_ready;
	logic [7:0]                in_data;
	logic [SDR_ADDR_W-1:0]     sdr_addr;
	logic [SDR_WORD_W-1:0]     sdr_data;
	logic [SDR_WORD_W/8-1:0]   sdr_be;
	logic                      sdr_req;
	logic                      sdr_ack;
	logic [BRAM_ADDR_W-1:0]    bram_addr;
	logic [7:0]                bram_data;
	logic [BRAM_BANKS-1:0]     bram_cs;
	logic                      bram_wr;
	logic [BOARD_CFG_W-1:0]    board_cfg;
	logic                      cfg_valid;
	logic                      reset_req;
	logic                      core_reset;
	logic                      load_done;

	// Entries hold {be, addr, data} and {cs, addr, data}
	logic [63:0]           got_sdr[$];
	logic [63:0]           exp_sdr[$];
	logic [63:0]           got_bram[$];
	logic [63:0]           exp_bram[$];
	int                    sdr_checked;
	int                    bram_checked;
	int                    stall_count;
	int                    mismatch_errs;
	int                    other_errs;
	logic [SDR_ADDR_W-1:0] next_sdr_addr;
	logic [31:0]           stim_lfsr;
	logic [31:0]           ack_lfsr;
	logic                  long_acks;

	m92_boot_top #(
		.SDR_ADDR_W  (SDR_ADDR_W),
		.BRAM_ADDR_W (BRAM_ADDR_W)
	) m92_boot_top_inst (.*);

	initial CLK_40M = 1'b0;
	always #(CLK_PERIOD/2) CLK_40M = !CLK_40M;

	// 32-bit Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, inout logic [31:0] state, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			state = lfsr_next(state);
			v = {v[30:0], state[0]};
		end
	endtask

	task automatic report_mismatch(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		mismatch_errs++;
		$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
	endtask

	task automatic log_error(input string msg);
		other_errs++;
		$display("error at %0t ns: %s", $time, msg);
	endtask

	// SDRAM port model
	initial begin : sdram_responder
		logic [31:0] delay;
		sdr_ack  = 1'b0;
		ack_lfsr = 32'h4d22;
		forever begin
			@(negedge CLK_40M);
			if (!reset && sdr_req !== sdr_ack) begin
				got_sdr.push_back(64'({sdr_be, sdr_addr, sdr_data}));
				if (long_acks) begin
					draw_bits(4, ack_lfsr, delay);
					delay = delay + 32'd8;
				end else
					draw_bits(3, ack_lfsr, delay);
				repeat (delay) @(negedge CLK_40M);
				sdr_ack = sdr_req;
			end
		end
	end

	always @(negedge CLK_40M) begin
		if (!reset && bram_wr === 1'b1)
			got_bram.push_back(64'({bram_cs, bram_addr, bram_data}));
	end

	task automatic send_byte(input logic [7:0] b);
		@(negedge CLK_40M);
		in_valid = 1'b1;
		in_data  = b;
		while (!in_ready) begin
			stall_count++;
			@(negedge CLK_40M);
		end
		@(negedge CLK_40M);
		// SPI bytes never arrive back to back
		in_valid = 1'b0;
	endtask

	task automatic send_header(input logic [7:0] code, input logic [23:0] len);
		send_byte(code);
		send_byte(len[23:16]);
		send_byte(len[15:8]);
		send_byte(len[7:0]);
	endtask

	task automatic send_sdr_region(input int len);
		logic [31:0] r;
		logic [7:0]  lo;
		send_header(SDR, 24'(len));
		for (int i = 0; i < len; i++) begin
			draw_bits(8, stim_lfsr, r);
			send_byte(r[7:0]);
			if (i % 2 == 0 && i == len - 1) begin
				// Odd tail goes out alone
				exp_sdr.push_back(64'({2'b01, next_sdr_addr, 8'h00, r[7:0]}));
				next_sdr_addr = next_sdr_addr + SDR_ADDR_W'(2);
			end else if (i % 2 == 0)
				lo = r[7:0];
			else begin
				exp_sdr.push_back(64'({2'b11, next_sdr_addr, r[7:0], lo}));
				next_sdr_addr = next_sdr_addr + SDR_ADDR_W'(2);
			end
		end
	endtask

	task automatic send_bram_region(input logic [7:0] code, input int len);
		logic [31:0]           r;
		logic [BRAM_BANKS-1:0] cs;
		cs = BRAM_BANKS'(1) << (code - 8'd1);
		send_header(code, 24'(len));
		for (int i = 0; i < len; i++) begin
			draw_bits(8, stim_lfsr, r);
			send_byte(r[7:0]);
			exp_bram.push_back(64'({cs, BRAM_ADDR_W'(i), r[7:0]}));
		end
	endtask

	task automatic check_sdr_words();
		while (got_sdr.size() < exp_sdr.size())
			@(negedge CLK_40M);
		for (int i = sdr_checked; i < exp_sdr.size(); i++) begin
			if (got_sdr[i] !== exp_sdr[i])
				report_mismatch($sformatf("SDRAM word %0d {be,addr,data}", i),
					got_sdr[i], exp_sdr[i]);
		end
		sdr_checked = exp_sdr.size();
	endtask

	task automatic check_bram_writes();
		while (got_bram.size() < exp_bram.size())
			@(negedge CLK_40M);
		for (int i = bram_checked; i < exp_bram.size(); i++) begin
			if (got_bram[i] !== exp_bram[i])
				report_mismatch($sformatf("BRAM write %0d {cs,addr,data}", i),
					got_bram[i], exp_bram[i]);
		end
		bram_checked = exp_bram.size();
	endtask

	task automatic verify_board_cfg();
		// core_reset, cfg_valid, in_ready, bram_wr, load_done, req^ack
		if ({core_reset, cfg_valid, in_ready, bram_wr, load_done, sdr_req ^ sdr_ack} !== 6'b101000)
			report_mismatch("outputs after reset",
				64'({core_reset, cfg_valid, in_ready, bram_wr, load_done, sdr_req ^ sdr_ack}),
				64'(6'b101000));
		@(negedge CLK_40M);
		download = 1'b1;
		send_byte(8'ha5);
		if (cfg_valid !== 1'b1)
			report_mismatch("cfg_valid", 64'(cfg_valid), 64'd1);
		if (board_cfg !== 8'ha5)
			report_mismatch("board_cfg", 64'(board_cfg), 64'ha5);
	endtask

	task automatic pack_even_region();
		send_sdr_region(8);
		check_sdr_words();
	endtask

	task automatic pack_odd_regions();
		send_sdr_region(5);
		send_sdr_region(4);
		check_sdr_words();
	endtask

	task automatic fill_bram_banks();
		logic req_before;
		req_before = sdr_req;
		send_bram_region(BRAM0, 3);
		send_bram_region(BRAM1, 2);
		send_bram_region(BRAM2, 4);
		send_bram_region(BRAM3, 1);
		check_bram_writes();
		if (sdr_req !== req_before || got_sdr.size() != sdr_checked)
			log_error("SDRAM request seen during a BRAM region");
	endtask

	task automatic stress_backpressure();
		int stalls_before;
		stalls_before = stall_count;
		long_acks = 1'b1;
		send_sdr_region(20);
		check_sdr_words();
		long_acks = 1'b0;
		if (stall_count == stalls_before)
			log_error("in_ready never went low under slow acknowledges");
	endtask

	task automatic finish_and_reset();
		send_header(END, 24'd0);
		while (!load_done)
			@(negedge CLK_40M);
		if (core_reset !== 1'b1)
			report_mismatch("core_reset before download end", 64'(core_reset), 64'd1);
		download = 1'b0;
		@(negedge CLK_40M);
		if (core_reset !== 1'b1)
			report_mismatch("core_reset 1 cycle after download fell", 64'(core_reset), 64'd1);
		@(negedge CLK_40M);
		if (core_reset !== 1'b0)
			report_mismatch("core_reset 2 cycles after download fell", 64'(core_reset), 64'd0);
		reset_req = 1'b1;
		@(negedge CLK_40M);
		if (core_reset !== 1'b1)
			report_mismatch("core_reset after reset_req rose", 64'(core_reset), 64'd1);
		repeat (3) @(negedge CLK_40M);
		if (core_reset !== 1'b1)
			report_mismatch("core_reset while reset_req held", 64'(core_reset), 64'd1);
		reset_req = 1'b0;
		@(negedge CLK_40M);
		if (core_reset !== 1'b0)
			report_mismatch("core_reset after reset_req fell", 64'(core_reset), 64'd0);
		if (got_sdr.size() != exp_sdr.size())
			log_error($sformatf("%0d SDRAM words written, %0d expected",
				got_sdr.size(), exp_sdr.size()));
	endtask

	initial begin
		reset         = 1'b1;
		download      = 1'b0;
		in_valid      = 1'b0;
		in_data       = 8'h00;
		reset_req     = 1'b0;
		long_acks     = 1'b0;
		stim_lfsr     = 32'h4d22;
		next_sdr_addr = '0;
		sdr_checked   = 0;
		bram_checked  = 0;
		stall_count   = 0;
		mismatch_errs = 0;
		other_errs    = 0;
		repeat (8) @(negedge CLK_40M);
		reset = 1'b0;
		verify_board_cfg();
		pack_even_region();
		pack_odd_regions();
		fill_bram_banks();
		stress_backpressure();
		finish_and_reset();
		$display("Checks done: %0d value mismatches, %0d other errors", mismatch_errs, other_errs);
		if (mismatch_errs + other_errs == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/m92_rom_pkg.sv
hdl/m92_mem_pkg.sv
hdl/rom_header_parser.sv
hdl/sdram_word_packer.sv
hdl/rom_loader.sv
hdl/core_reset_ctrl.sv
hdl/m92_boot_top.sv
verif/m92_boot_checker.sv
verif/m92_boot_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= m92_boot_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
